//--- Bender.yml
package:
  name: ppu_pixel_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/ppu_pkg.sv
      - logic/raster_timer.sv
      - logic/pixel_mixer.sv
      - logic/line_buffer.sv
      - logic/ppu_pixel_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_ppu_pixel_core.sv

//--- logic/line_buffer.sv
`default_nettype none

`include "ppu_settings.svh"

module line_buffer import ppu_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  logic       ppu_clk_en,
    input  logic       render_window,
    input  logic       line_end,
    input  pal_color_t pix_color,
    input  pix_idx_t   disp_idx,
    output pal_color_t disp_color
);

    pal_color_t render_buf [`SCREEN_WIDTH];
    pal_color_t disp_buf [`SCREEN_WIDTH];
    pix_idx_t   wr_pos;
    // all positions written since the last swap
    logic       line_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pos    <= '0;
            line_full <= 1'b0;
            for (int i = 0; i < `SCREEN_WIDTH; i++) begin
                render_buf[i] <= '0;
            end
        end else if (ppu_clk_en) begin
            if (line_end) begin
                wr_pos    <= '0;
                line_full <= 1'b0;
            end else if (render_window) begin
                render_buf[wr_pos] <= pix_color;
                wr_pos             <= wr_pos + pix_idx_t'(1);
                if (wr_pos == pix_idx_t'(`SCREEN_WIDTH - 1)) begin
                    line_full <= 1'b1;
                end
            end
        end
    end

    // whole line handed over on the last dot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SCREEN_WIDTH; i++) begin
                disp_buf[i] <= '0;
            end
        end else if (ppu_clk_en && line_end) begin
            disp_buf <= render_buf;
        end
    end

    assign disp_color = disp_buf[disp_idx];

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        ppu_clk_en && line_full |-> !render_window || line_end);

endmodule

`default_nettype wire

//--- logic/pixel_mixer.sv
`default_nettype none

`include "ppu_settings.svh"

module pixel_mixer import ppu_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  logic       ppu_clk_en,
    input  mask_t      mask,
    input  color_idx_t bg_idx,
    input  color_idx_t sp_idx,
    input  logic       sp_prio,
    input  logic       sp_zero,
    input  logic       render_window,
    input  logic       left_edge,
    input  logic       pal_we,
    input  pal_addr_t  pal_waddr,
    input  pal_color_t pal_wdata,
    output pal_color_t pix_color,
    output logic       sp_zero_hit
);

    pal_color_t pal_mem [`PAL_ENTRIES];

    logic       bg_on, sp_on;
    color_idx_t bg_gated, sp_gated;
    logic       bg_opaque, sp_opaque;
    logic       sp_wins;
    pal_addr_t  pal_raddr;
    pal_color_t pal_entry;

    // layer enable and left column clip
    assign bg_on = mask[`MASK_BG_EN] && !(left_edge && !mask[`MASK_BG_LEFT]);
    assign sp_on = mask[`MASK_SP_EN] && !(left_edge && !mask[`MASK_SP_LEFT]);

    assign bg_gated = bg_on ? bg_idx : '0;
    assign sp_gated = sp_on ? sp_idx : '0;

    assign bg_opaque = (bg_gated[1:0] != 2'b00);
    assign sp_opaque = (sp_gated[1:0] != 2'b00);

    // sp_prio set puts the sprite behind an opaque background
    assign sp_wins = sp_opaque && (!bg_opaque || !sp_prio);

    always_comb begin
        if (sp_wins) begin
            pal_raddr = {1'b1, sp_gated};
        end else begin
            pal_raddr = {1'b0, bg_gated};
        end
    end

    // flat palette, no entry mirroring
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PAL_ENTRIES; i++) begin
                pal_mem[i] <= '0;
            end
        end else if (ppu_clk_en && pal_we) begin
            pal_mem[pal_waddr] <= pal_wdata;
        end
    end

    assign pal_entry = pal_mem[pal_raddr];

    // greyscale keeps only the luma column
    assign pix_color = mask[`MASK_GREY] ? (pal_entry & `GREY_KEEP) : pal_entry;

    assign sp_zero_hit = render_window && sp_zero && bg_opaque && sp_opaque;

    a_pal_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        (ppu_clk_en && pal_we) |-> !$isunknown(pal_waddr));

endmodule

`default_nettype wire

//--- logic/ppu_pixel_core.sv
`default_nettype none

`include "ppu_settings.svh"

module ppu_pixel_core import ppu_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  logic       ppu_clk_en,
    input  logic       nmi_en,
    input  mask_t      mask,
    input  color_idx_t bg_idx,
    input  color_idx_t sp_idx,
    input  logic       sp_prio,
    input  logic       sp_zero,
    input  logic       pal_we,
    input  pal_addr_t  pal_waddr,
    input  pal_color_t pal_wdata,
    input  pix_idx_t   disp_idx,
    output pal_color_t disp_color,
    output logic       status_vblank,
    output logic       status_sp_zero,
    output logic       nmi_n
);

    logic       render_window;
    logic       left_edge;
    logic       line_end;
    logic       sp_zero_hit;
    pal_color_t pix_color;

    // dot and line timing
    raster_timer i_raster_timer (
        .clk            (clk),
        .rst_n          (rst_n),
        .ppu_clk_en     (ppu_clk_en),
        .nmi_en         (nmi_en),
        .sp_zero_hit    (sp_zero_hit),
        .render_window  (render_window),
        .left_edge      (left_edge),
        .line_end       (line_end),
        .status_vblank  (status_vblank),
        .status_sp_zero (status_sp_zero),
        .nmi_n          (nmi_n)
    );

    pixel_mixer i_pixel_mixer (
        .clk           (clk),
        .rst_n         (rst_n),
        .ppu_clk_en    (ppu_clk_en),
        .mask          (mask),
        .bg_idx        (bg_idx),
        .sp_idx        (sp_idx),
        .sp_prio       (sp_prio),
        .sp_zero       (sp_zero),
        .render_window (render_window),
        .left_edge     (left_edge),
        .pal_we        (pal_we),
        .pal_waddr     (pal_waddr),
        .pal_wdata     (pal_wdata),
        .pix_color     (pix_color),
        .sp_zero_hit   (sp_zero_hit)
    );

    // finished line goes to the display side
    line_buffer i_line_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .ppu_clk_en    (ppu_clk_en),
        .render_window (render_window),
        .line_end      (line_end),
        .pix_color     (pix_color),
        .disp_idx      (disp_idx),
        .disp_color    (disp_color)
    );

endmodule

`default_nettype wire

//--- logic/ppu_pkg.sv
`default_nettype none

`include "ppu_settings.svh"

package ppu_pkg;

    // raster position
    typedef logic [$clog2(`DOTS_PER_LINE)-1:0] dot_t;
    typedef logic [$clog2(`LINES_PER_FRAME)-1:0] line_t;

    // {palette group, pixel}, pixel 0 is transparent
    typedef logic [3:0] color_idx_t;
    // top bit picks the sprite half
    typedef logic [$clog2(`PAL_ENTRIES)-1:0] pal_addr_t;
    typedef logic [5:0] pal_color_t;
    typedef logic [7:0] mask_t;
    typedef logic [$clog2(`SCREEN_WIDTH)-1:0] pix_idx_t;

    // vertical phase of the frame
    typedef enum logic [1:0] {PRE_SL, VIS_SL, POST_SL, VBLANK_SL} vs_state_t;

    // horizontal phase of the line
    typedef enum logic [2:0] {
        SL_PRE_CYC,
        IDLE_CYC,
        SP_PRE_CYC,
        TL_PRE_CYC,
        GARB_CYC
    } hs_state_t;

endpackage

`default_nettype wire

//--- logic/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// raster geometry
`define SCREEN_WIDTH        256
`define DOTS_PER_LINE       341
`define LINES_PER_FRAME     262
`define FIRST_VISIBLE_LINE  1
`define LAST_VISIBLE_LINE   240
`define VBLANK_LINE         241
`define NMI_DOTS            3
`define LEFT_CLIP_DOTS      8
`define PAL_ENTRIES         32

// ppumask bit positions
`define MASK_GREY           0
`define MASK_BG_LEFT        1
`define MASK_SP_LEFT        2
`define MASK_BG_EN          3
`define MASK_SP_EN          4

// colour bits that survive greyscale
`define GREY_KEEP           6'h30

`endif

//--- logic/raster_timer.sv
`default_nettype none

`include "ppu_settings.svh"

module raster_timer import ppu_pkg::*; (
    input  wire  clk,
    input  wire  rst_n,
    input  logic ppu_clk_en,
    input  logic nmi_en,
    input  logic sp_zero_hit,
    output logic render_window,
    output logic left_edge,
    output logic line_end,
    output logic status_vblank,
    output logic status_sp_zero,
    output logic nmi_n
);

    localparam dot_t  LAST_DOT    = dot_t'(`DOTS_PER_LINE - 1);
    localparam dot_t  LAST_PIXEL  = dot_t'(`SCREEN_WIDTH - 1);
    localparam dot_t  SP_END_DOT  = dot_t'(320);
    localparam dot_t  TL_END_DOT  = dot_t'(336);
    localparam line_t LAST_LINE   = line_t'(`LINES_PER_FRAME - 1);
    localparam line_t PRE_LINE    = line_t'(`FIRST_VISIBLE_LINE - 1);
    localparam line_t LAST_VIS    = line_t'(`LAST_VISIBLE_LINE);
    localparam line_t VBLANK_LINE = line_t'(`VBLANK_LINE);

    dot_t      dot;
    line_t     line;
    vs_state_t vs_state, vs_next;
    hs_state_t hs_state, hs_next;
    logic      last_dot;
    logic      frame_clr;

    assign last_dot = (dot == LAST_DOT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dot  <= '0;
            line <= '0;
        end else if (ppu_clk_en) begin
            if (last_dot) begin
                dot  <= '0;
                line <= (line == LAST_LINE) ? '0 : line + line_t'(1);
            end else begin
                dot <= dot + dot_t'(1);
            end
        end
    end

    // horizontal phases
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= SL_PRE_CYC;
        end else if (ppu_clk_en) begin
            hs_state <= hs_next;
        end
    end

    always_comb begin
        hs_next = hs_state;
        case (hs_state)
            SL_PRE_CYC: hs_next = (dot < LAST_PIXEL) ? SL_PRE_CYC : IDLE_CYC;
            IDLE_CYC:   hs_next = SP_PRE_CYC;
            SP_PRE_CYC: hs_next = (dot < SP_END_DOT) ? SP_PRE_CYC : TL_PRE_CYC;
            TL_PRE_CYC: hs_next = (dot < TL_END_DOT) ? TL_PRE_CYC : GARB_CYC;
            GARB_CYC:   hs_next = last_dot ? SL_PRE_CYC : GARB_CYC;
            default:    hs_next = SL_PRE_CYC;
        endcase
    end

    // vertical phases change on the last dot of a line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_state <= PRE_SL;
        end else if (ppu_clk_en) begin
            vs_state <= vs_next;
        end
    end

    always_comb begin
        vs_next = vs_state;
        case (vs_state)
            PRE_SL:    vs_next = (last_dot && line == PRE_LINE) ? VIS_SL : PRE_SL;
            VIS_SL:    vs_next = (last_dot && line == LAST_VIS) ? POST_SL : VIS_SL;
            POST_SL:   vs_next = (last_dot && line == VBLANK_LINE) ? VBLANK_SL : POST_SL;
            VBLANK_SL: vs_next = (last_dot && line == LAST_LINE) ? PRE_SL : VBLANK_SL;
            default:   vs_next = PRE_SL;
        endcase
    end

    assign render_window = (vs_state == VIS_SL) && (hs_state == SL_PRE_CYC);
    assign left_edge     = (hs_state == SL_PRE_CYC) && (dot < dot_t'(`LEFT_CLIP_DOTS));
    assign line_end      = (hs_state == GARB_CYC) && last_dot;

    // status flags clear on the first dot of the pre-render line
    assign frame_clr = (vs_state == PRE_SL) && (dot == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_vblank  <= 1'b0;
            status_sp_zero <= 1'b0;
        end else if (ppu_clk_en) begin
            if (frame_clr) begin
                status_vblank  <= 1'b0;
                status_sp_zero <= 1'b0;
            end else begin
                if (vs_state == POST_SL && dot == '0) begin
                    status_vblank <= 1'b1;
                end
                if (sp_zero_hit) begin
                    status_sp_zero <= 1'b1;
                end
            end
        end
    end

    // nmi held low for the first few dots of vblank
    assign nmi_n = !(nmi_en && vs_state == POST_SL && dot < dot_t'(`NMI_DOTS));

    a_dot_range: assert property (@(posedge clk) disable iff (!rst_n)
        dot <= LAST_DOT);

    a_end_outside_window: assert property (@(posedge clk) disable iff (!rst_n)
        !(last_dot && render_window));

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/ppu_pkg.sv
logic/raster_timer.sv
logic/pixel_mixer.sv
logic/line_buffer.sv
logic/ppu_pixel_core.sv
verification/tb_ppu_pixel_core.sv

//--- verification/tb_ppu_pixel_core.sv
`default_nettype none

`include "ppu_settings.svh"

module tb_ppu_pixel_core import ppu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS = 13;

    typedef struct packed {
        mask_t      mask;
        color_idx_t bg;
        color_idx_t sp;
        logic       prio;
        logic       spz;
        pal_addr_t  addr;
        pal_addr_t  addr_left;
        logic       hit;
        logic       hit_left;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        ppu_clk_en;
    logic        nmi_en;
    mask_t       mask;
    color_idx_t  bg_idx;
    color_idx_t  sp_idx;
    logic        sp_prio;
    logic        sp_zero;
    logic        pal_we;
    pal_addr_t   pal_waddr;
    pal_color_t  pal_wdata;
    pix_idx_t    disp_idx;
    pal_color_t  disp_color;
    logic        status_vblank;
    logic        status_sp_zero;
    logic        nmi_n;

    // visible line n uses row n-1, every other line the idle row at the end
    row_t        rows [NUM_ROWS + 1];
    pal_color_t  pal_copy [`PAL_ENTRIES];
    pal_color_t  render_model [`SCREEN_WIDTH];
    pal_color_t  disp_model [`SCREEN_WIDTH];
    int          cur_line;
    int          cur_dot;
    int          cur_sel;
    int          pal_count;
    logic        vblank_model;
    logic        sp_zero_model;
    logic        nmi_on;
    logic        seen_nmi_n;
    logic        seen_vblank;
    logic [31:0] lcg_state;

    ppu_pixel_core i_ppu_pixel_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .ppu_clk_en     (ppu_clk_en),
        .nmi_en         (nmi_en),
        .mask           (mask),
        .bg_idx         (bg_idx),
        .sp_idx         (sp_idx),
        .sp_prio        (sp_prio),
        .sp_zero        (sp_zero),
        .pal_we         (pal_we),
        .pal_waddr      (pal_waddr),
        .pal_wdata      (pal_wdata),
        .disp_idx       (disp_idx),
        .disp_color     (disp_color),
        .status_vblank  (status_vblank),
        .status_sp_zero (status_sp_zero),
        .nmi_n          (nmi_n)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic pal_color_t expected_color(input pal_addr_t addr, input mask_t m);
        pal_color_t c;
        c = pal_copy[addr];
        if (m[`MASK_GREY]) begin
            c = c & `GREY_KEEP;
        end
        return c;
    endfunction

    task automatic load_table();
        // mask, bg, sp, prio, spz, addr 8..255, addr 0..7, hit 8..255, hit 0..7
        rows[0]  = {8'h1E, 4'h4, 4'h8, 1'b0, 1'b0, 5'h04, 5'h04, 1'b0, 1'b0};
        rows[1]  = {8'h1E, 4'h5, 4'h0, 1'b0, 1'b0, 5'h05, 5'h05, 1'b0, 1'b0};
        rows[2]  = {8'h1E, 4'h4, 4'h6, 1'b0, 1'b0, 5'h16, 5'h16, 1'b0, 1'b0};
        rows[3]  = {8'h1E, 4'h7, 4'h9, 1'b0, 1'b0, 5'h19, 5'h19, 1'b0, 1'b0};
        rows[4]  = {8'h1E, 4'h7, 4'h9, 1'b1, 1'b0, 5'h07, 5'h07, 1'b0, 1'b0};
        rows[5]  = {8'h1C, 4'h3, 4'h0, 1'b0, 1'b0, 5'h03, 5'h00, 1'b0, 1'b0};
        rows[6]  = {8'h1A, 4'h2, 4'hE, 1'b0, 1'b0, 5'h1E, 5'h02, 1'b0, 1'b0};
        rows[7]  = {8'h16, 4'h5, 4'hA, 1'b1, 1'b0, 5'h1A, 5'h1A, 1'b0, 1'b0};
        rows[8]  = {8'h0E, 4'hD, 4'hB, 1'b0, 1'b0, 5'h0D, 5'h0D, 1'b0, 1'b0};
        rows[9]  = {8'h1F, 4'hB, 4'h0, 1'b0, 1'b0, 5'h0B, 5'h0B, 1'b0, 1'b0};
        rows[10] = {8'h1E, 4'h4, 4'h5, 1'b0, 1'b1, 5'h15, 5'h15, 1'b0, 1'b0};
        rows[11] = {8'h1A, 4'h1, 4'h6, 1'b1, 1'b1, 5'h01, 5'h01, 1'b1, 1'b0};
        rows[12] = {8'h1E, 4'h6, 4'h3, 1'b0, 1'b0, 5'h13, 5'h13, 1'b0, 1'b0};
        rows[13] = {8'h00, 4'h0, 4'h0, 1'b0, 1'b0, 5'h00, 5'h00, 1'b0, 1'b0};
    endtask

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t ns, line %0d dot %0d: %s", $time, cur_line, cur_dot, what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // outputs have been stable since the last rising edge
    task automatic check_outputs();
        logic exp_nmi_n;
        exp_nmi_n = !(nmi_en && cur_line == `VBLANK_LINE && cur_dot < `NMI_DOTS);
        seen_nmi_n = nmi_n;
        seen_vblank = status_vblank;
        assert (disp_color === disp_model[disp_idx]) else
            report_mismatch($sformatf("disp_color[%0d] is %h, expected %h",
                disp_idx, disp_color, disp_model[disp_idx]));
        assert (nmi_n === exp_nmi_n) else
            report_mismatch($sformatf("nmi_n is %b, expected %b", nmi_n, exp_nmi_n));
        assert (status_vblank === vblank_model) else
            report_mismatch($sformatf("status_vblank is %b, expected %b",
                status_vblank, vblank_model));
        assert (status_sp_zero === sp_zero_model) else
            report_mismatch($sformatf("status_sp_zero is %b, expected %b",
                status_sp_zero, sp_zero_model));
    endtask

    task automatic drive_inputs(input logic en);
        logic [31:0] rnd;
        cur_sel = (cur_line >= 1 && cur_line <= NUM_ROWS) ? cur_line - 1 : NUM_ROWS;
        ppu_clk_en = en;
        nmi_en = nmi_on;
        mask = rows[cur_sel].mask;
        bg_idx = rows[cur_sel].bg;
        sp_idx = rows[cur_sel].sp;
        sp_prio = rows[cur_sel].prio;
        sp_zero = rows[cur_sel].spz;
        disp_idx = pix_idx_t'(cur_dot);
        pal_we = (pal_count < `PAL_ENTRIES);
        if (pal_we) begin
            rnd = lcg_next();
            pal_waddr = pal_addr_t'(pal_count);
            // random top bit, low bits unique per entry
            pal_wdata = {rnd[16], pal_addr_t'(pal_count)};
        end
    endtask

    // one enabled dot of the reference model
    task automatic advance_model();
        logic in_window;
        logic left;
        in_window = cur_line >= `FIRST_VISIBLE_LINE && cur_line <= `LAST_VISIBLE_LINE
            && cur_dot < `SCREEN_WIDTH;
        left = (cur_dot < `LEFT_CLIP_DOTS);
        if (in_window) begin
            render_model[cur_dot] = expected_color(
                left ? rows[cur_sel].addr_left : rows[cur_sel].addr, rows[cur_sel].mask);
        end
        if (cur_line == 0 && cur_dot == 0) begin
            vblank_model = 1'b0;
            sp_zero_model = 1'b0;
        end else begin
            if (cur_line == `VBLANK_LINE && cur_dot == 0) begin
                vblank_model = 1'b1;
            end
            if (in_window && (left ? rows[cur_sel].hit_left : rows[cur_sel].hit)) begin
                sp_zero_model = 1'b1;
            end
        end
        if (pal_we) begin
            pal_copy[pal_waddr] = pal_wdata;
            pal_count++;
        end
        if (cur_dot == `DOTS_PER_LINE - 1) begin
            for (int i = 0; i < `SCREEN_WIDTH; i++) begin
                disp_model[i] = render_model[i];
            end
            cur_dot = 0;
            cur_line = (cur_line == `LINES_PER_FRAME - 1) ? 0 : cur_line + 1;
        end else begin
            cur_dot++;
        end
    endtask

    task automatic run_cycle();
        logic [31:0] rnd;
        logic        en;
        @(negedge clk);
        check_outputs();
        en = 1'b1;
        // random enable gaps on one visible line and on the vblank line
        if (cur_line == 4 || cur_line == `VBLANK_LINE) begin
            rnd = lcg_next();
            en = (rnd[17:16] != 2'b00);
        end
        drive_inputs(en);
        @(posedge clk);
        if (en) begin
            advance_model();
        end
    endtask

    task automatic run_until(input int tl, input int td, input int limit, input string what);
        int n;
        n = 0;
        while (!(cur_line == tl && cur_dot == td)) begin
            if (n >= limit) begin
                report_timeout({"never reached the ", what});
            end else begin
                run_cycle();
                n++;
            end
        end
    endtask

    task automatic wait_nmi_low(input int limit);
        int n;
        n = 0;
        seen_nmi_n = 1'b1;
        while (seen_nmi_n !== 1'b0) begin
            if (n >= limit) begin
                report_timeout("nmi_n never went low at the start of vblank");
            end else begin
                run_cycle();
                n++;
            end
        end
    endtask

    task automatic wait_vblank_high(input int limit);
        int n;
        n = 0;
        seen_vblank = 1'b0;
        while (seen_vblank !== 1'b1) begin
            if (n >= limit) begin
                report_timeout("status_vblank never went high");
            end else begin
                run_cycle();
                n++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        ppu_clk_en = 1'b0;
        nmi_en = 1'b0;
        mask = '0;
        bg_idx = '0;
        sp_idx = '0;
        sp_prio = 1'b0;
        sp_zero = 1'b0;
        pal_we = 1'b0;
        pal_waddr = '0;
        pal_wdata = '0;
        disp_idx = '0;
        lcg_state = 32'd5200;
        cur_line = 0;
        cur_dot = 0;
        cur_sel = NUM_ROWS;
        pal_count = 0;
        vblank_model = 1'b0;
        sp_zero_model = 1'b0;
        nmi_on = 1'b1;
        for (int i = 0; i < `SCREEN_WIDTH; i++) begin
            render_model[i] = '0;
            disp_model[i] = '0;
        end
        for (int i = 0; i < `PAL_ENTRIES; i++) begin
            pal_copy[i] = '0;
        end
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // first frame, palette loads on the pre-render line
        run_until(`LAST_VISIBLE_LINE, `DOTS_PER_LINE - 1, 100000, "last visible dot");
        wait_nmi_low(16);
        run_until(0, 0, 30000, "pre-render line of the second frame");
        // second frame without nmi
        nmi_on = 1'b0;
        run_until(`LAST_VISIBLE_LINE, `DOTS_PER_LINE - 1, 100000, "last visible dot");
        wait_vblank_high(16);
        run_until(1, 0, 30000, "first visible line of the third frame");
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
